/* testbench/ship_stim.txt */
# frames left right fire en0_x en0_y en1_x en1_y en2_x en2_y probes, then probe x y pairs
# probes that have no x y pair on their line are picked at random
1   0 0 0  0 0  0 0  0 0  4  512 690  480 727  100 100
1   1 0 0  0 0  0 0  0 0  4  476 680  475 680  539 680  540 680
130 1 0 0  0 0  0 0  0 0  4  0 680  63 680  64 680
245 0 1 0  0 0  0 0  0 0  4  960 680  1023 680  959 680
1   0 0 1  0 0  0 0  0 0  4  990 660  993 671  994 665  989 665
1   0 1 0  0 0  0 0  0 0  3  991 652  991 651  960 680
90  0 0 0  0 0  0 0  0 0  2  990 4
1   0 0 0  1000 700  0 0  0 0  3  990 690  960 680
3   0 0 1  0 0  0 0  0 0  3  990 668  1000 690

/* sim.f */
rtl/ship_pkg.sv
rtl/vga_if.sv
rtl/ship_position_ctl.sv
rtl/collision_detect.sv
rtl/ship_sprite_rom.sv
rtl/ship_sprite_draw.sv
rtl/missile_ctl.sv
rtl/missile_draw.sv
rtl/draw_ship.sv
testbench/draw_ship_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build draw_ship_tb with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --timing -Wno-fatal --top-module draw_ship_tb \
  --Mdir obj_dir -o draw_ship_sim -f sim.f > "$log" 2>&1 &&
  ./obj_dir/draw_ship_sim >> "$log" 2>&1 ||
  { echo "build or simulation error, see $log"; exit 1; }
if grep -q "Result: FAILED" "$log"; then
  echo "simulation failed, see $log"
  exit 1
fi
grep -q "Result: PASSED" "$log" || { echo "no result found in $log"; exit 1; }
echo "simulation passed"

/* testbench/draw_ship_tb.sv */
`timescale 1ns/10ps

module draw_ship_tb;
  import ship_pkg::*;

  localparam int   MAX_LINES  = 16;
  localparam int   MAX_PROBES = 4;
  localparam int   FRAME_CYC  = 7;
  localparam int   PIPE_DEPTH = 3;
  localparam int   RESET_CYC  = 16;
  localparam rgb_t BG_RGB     = 12'h555;

  logic   pclk = 1'b0;
  logic   rst_n_i;
  logic   left_i, right_i, missile_button_i;
  logic   hsync_i, hblnk_i, vsync_i, vblnk_i;
  coord_t hcount_i, vcount_i;
  rgb_t   rgb_i;
  coord_t en_x_missile_i [ENEMY_MISSILES];
  coord_t en_y_missile_i [ENEMY_MISSILES];
  logic   hsync_o, hblnk_o, vsync_o, vblnk_o;
  coord_t hcount_o, vcount_o, xpos_missile_o, ypos_missile_o;
  rgb_t   rgb_o;
  logic   on_missile_o, ship_dead_o;

  // reference model state
  coord_t m_ship_x, m_x, m_y;
  logic   m_dead, m_on, m_vsync_d;

  // expected output delayed to match the DUT latency
  logic       cur_valid;
  rgb_t       cur_rgb;
  logic       pipe_valid [PIPE_DEPTH];
  rgb_t       pipe_rgb [PIPE_DEPTH];
  coord_t     pipe_hc [PIPE_DEPTH];
  coord_t     pipe_vc [PIPE_DEPTH];
  logic [3:0] pipe_sync [PIPE_DEPTH];

  // one row per stim line and its field count
  int s_f [MAX_LINES][19];
  int s_cnt [MAX_LINES];
  int num_lines, stim_cycles, checks, errors, err_before;
  int cycle_count = 0;
  int cycle_limit = 0;

  draw_ship dut (.*);

  always #5 pclk = ~pclk;

  always @(posedge pclk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: %0d cycles passed and the tests did not finish", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic enemy_hit(input coord_t sx);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < ENEMY_MISSILES; i++) begin
      if (int'(en_x_missile_i[i]) >= int'(sx) && int'(en_x_missile_i[i]) < int'(sx) + SHIP_W &&
          int'(en_y_missile_i[i]) >= SHIP_Y && int'(en_y_missile_i[i]) < SHIP_Y + SHIP_H) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic coord_t moved_x(input coord_t sx, input logic l, input logic r);
    int nx;
    nx = int'(sx);
    if (l && !r) begin
      nx = nx - SHIP_STEP;
    end else if (r && !l) begin
      nx = nx + SHIP_STEP;
    end
    if (nx < 0) begin
      nx = 0;
    end else if (nx > SCREEN_W - SHIP_W) begin
      nx = SCREEN_W - SHIP_W;
    end
    return coord_t'(nx);
  endfunction

  // colour of one pixel after the ship and missile overlays
  function automatic rgb_t expect_rgb(input int x, input int y, input logic blank, input rgb_t bg);
    rgb_t c;
    rgb_t e;
    e = bg;
    if (!blank && !m_dead && x >= int'(m_ship_x) && x < int'(m_ship_x) + SHIP_W &&
        y >= SHIP_Y && y < SHIP_Y + SHIP_H) begin
      c = sprite_color(y - SHIP_Y, x - int'(m_ship_x));
      if (c != TRANSPARENT) begin
        e = c;
      end
    end
    if (!blank && m_on && x >= int'(m_x) && x < int'(m_x) + MISSILE_W &&
        y >= int'(m_y) && y < int'(m_y) + MISSILE_H) begin
      e = MISSILE_COLOR;
    end
    return e;
  endfunction

  always @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      m_vsync_d <= 1'b0;
      m_ship_x  <= coord_t'(SHIP_X_INIT);
      m_dead    <= 1'b0;
      m_on      <= 1'b0;
      m_x       <= '0;
      m_y       <= '0;
    end else begin
      m_vsync_d <= vsync_i;
      if (enemy_hit(m_ship_x)) begin
        m_dead <= 1'b1;
      end
      if (vsync_i && !m_vsync_d) begin
        m_ship_x <= moved_x(m_ship_x, left_i, right_i);
      end
      if (missile_button_i && !m_on && !m_dead) begin
        m_on <= 1'b1;
        m_x  <= coord_t'(int'(m_ship_x) + SHIP_W / 2 - MISSILE_W / 2);
        m_y  <= coord_t'(SHIP_Y - MISSILE_H);
      end else if (vsync_i && !m_vsync_d && m_on) begin
        if (int'(m_y) < MISSILE_STEP) begin
          m_on <= 1'b0;
        end else begin
          m_y <= m_y - coord_t'(MISSILE_STEP);
        end
      end
    end
  end

  always @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PIPE_DEPTH; i++) begin
        pipe_valid[i] <= 1'b0;
      end
    end else begin
      pipe_valid[0] <= cur_valid;
      pipe_rgb[0]   <= cur_rgb;
      pipe_hc[0]    <= hcount_i;
      pipe_vc[0]    <= vcount_i;
      pipe_sync[0]  <= {hsync_i, hblnk_i, vsync_i, vblnk_i};
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
        pipe_rgb[i]   <= pipe_rgb[i-1];
        pipe_hc[i]    <= pipe_hc[i-1];
        pipe_vc[i]    <= pipe_vc[i-1];
        pipe_sync[i]  <= pipe_sync[i-1];
      end
    end
  end

  task automatic check_rgb(input string what, input rgb_t got, input rgb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_coord(input string what, input coord_t got, input coord_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // outputs leave the DUT three cycles after their pixel went in
  always @(negedge pclk) begin
    if (pipe_valid[PIPE_DEPTH-1]) begin
      check_rgb($sformatf("rgb_o at %0d,%0d", pipe_hc[2], pipe_vc[2]), rgb_o, pipe_rgb[2]);
      check_coord("hcount_o", hcount_o, pipe_hc[2]);
      check_coord("vcount_o", vcount_o, pipe_vc[2]);
      check_bit("hsync_o", hsync_o, pipe_sync[2][3]);
      check_bit("hblnk_o", hblnk_o, pipe_sync[2][2]);
      check_bit("vsync_o", vsync_o, pipe_sync[2][1]);
      check_bit("vblnk_o", vblnk_o, pipe_sync[2][0]);
    end
  end

  task automatic drive_cycle(input int x, input int y, input logic hs, input logic hb,
                             input logic vs, input logic vb, input rgb_t rgb);
    @(negedge pclk);
    hcount_i  = coord_t'(x);
    vcount_i  = coord_t'(y);
    hsync_i   = hs;
    hblnk_i   = hb;
    vsync_i   = vs;
    vblnk_i   = vb;
    rgb_i     = rgb;
    cur_valid = 1'b1;
    cur_rgb   = expect_rgb(x, y, hb | vb, rgb);
  endtask

  task automatic check_state();
    check_coord("xpos_missile_o", xpos_missile_o, m_x);
    check_coord("ypos_missile_o", ypos_missile_o, m_y);
    check_bit("on_missile_o", on_missile_o, m_on);
    check_bit("ship_dead_o", ship_dead_o, m_dead);
  endtask

  task automatic load_stim(output int total);
    int    fd;
    int    n;
    string line;
    total = 0;
    num_lines = 0;
    fd = $fopen("testbench/ship_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file testbench/ship_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd) && num_lines < MAX_LINES) begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = num_lines;
          s_cnt[n] = $sscanf(line,
            "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
            s_f[n][0], s_f[n][1], s_f[n][2], s_f[n][3], s_f[n][4], s_f[n][5],
            s_f[n][6], s_f[n][7], s_f[n][8], s_f[n][9], s_f[n][10], s_f[n][11],
            s_f[n][12], s_f[n][13], s_f[n][14], s_f[n][15], s_f[n][16], s_f[n][17],
            s_f[n][18]);
          if (s_f[n][10] > MAX_PROBES) begin
            s_f[n][10] = MAX_PROBES;
          end
          total += s_f[n][0] * (FRAME_CYC + 2 * s_f[n][10]);
          num_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  // vsync pulse with the controls, settle, then the probe pixels
  task automatic run_frame(input int i);
    int px;
    int py;
    drive_cycle(0, 0, 1'b0, 1'b1, 1'b0, 1'b1, '0);
    left_i           = (s_f[i][1] != 0);
    right_i          = (s_f[i][2] != 0);
    missile_button_i = (s_f[i][3] != 0);
    for (int k = 0; k < ENEMY_MISSILES; k++) begin
      en_x_missile_i[k] = coord_t'(s_f[i][4 + 2 * k]);
      en_y_missile_i[k] = coord_t'(s_f[i][5 + 2 * k]);
    end
    repeat (2) drive_cycle(0, 0, 1'b0, 1'b1, 1'b1, 1'b1, '0);
    repeat (4) drive_cycle(0, 0, 1'b0, 1'b1, 1'b0, 1'b1, '0);
    check_state();
    for (int p = 0; p < s_f[i][10]; p++) begin
      if (12 + 2 * p < s_cnt[i]) begin
        px = s_f[i][11 + 2 * p];
        py = s_f[i][12 + 2 * p];
      end else begin
        px = int'($urandom % SCREEN_W);
        py = int'($urandom % 768);
      end
      drive_cycle(px, py, 1'b0, 1'b0, 1'b0, 1'b0, BG_RGB);
      // same pixel again, in horizontal or vertical blanking by turns
      if (p % 2 == 0) begin
        drive_cycle(px, py, 1'b1, 1'b1, 1'b0, 1'b0, BG_RGB);
      end else begin
        drive_cycle(px, py, 1'b0, 1'b0, 1'b0, 1'b1, BG_RGB);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h9dc6));
    rst_n_i          = 1'b0;
    left_i           = 1'b0;
    right_i          = 1'b0;
    missile_button_i = 1'b0;
    hcount_i         = '0;
    vcount_i         = '0;
    hsync_i          = 1'b0;
    hblnk_i          = 1'b0;
    vsync_i          = 1'b0;
    vblnk_i          = 1'b0;
    rgb_i            = '0;
    for (int k = 0; k < ENEMY_MISSILES; k++) begin
      en_x_missile_i[k] = '0;
      en_y_missile_i[k] = '0;
    end
    cur_valid = 1'b0;
    cur_rgb   = '0;
    checks    = 0;
    errors    = 0;
    load_stim(stim_cycles);
    cycle_limit = 2 * (RESET_CYC + stim_cycles + 2 * PIPE_DEPTH);

    repeat (RESET_CYC) @(negedge pclk);
    check_rgb("rgb_o in reset", rgb_o, '0);
    check_coord("hcount_o in reset", hcount_o, '0);
    check_bit("vsync_o in reset", vsync_o, 1'b0);
    check_state();
    rst_n_i = 1'b1;
    $display("test 0 reset: %0d errors", errors);

    for (int i = 0; i < num_lines; i++) begin
      err_before = errors;
      repeat (s_f[i][0]) run_frame(i);
      // let the checks of this falling edge finish first
      @(posedge pclk);
      $display("test %0d (%0d frames): %0d errors", i + 1, s_f[i][0], errors - err_before);
    end
    // drain the last pixels through the pipeline
    repeat (PIPE_DEPTH + 1) drive_cycle(0, 0, 1'b0, 1'b1, 1'b0, 1'b1, '0);
    @(posedge pclk);

    $display("%0d tests, %0d checks, %0d errors", num_lines + 1, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* rtl/draw_ship.sv */
`timescale 1ns/10ps

module draw_ship (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  logic             left_i,
  input  logic             right_i,
  input  logic             missile_button_i,

  input  ship_pkg::coord_t hcount_i,
  input  logic             hsync_i,
  input  logic             hblnk_i,
  input  ship_pkg::coord_t vcount_i,
  input  logic             vsync_i,
  input  logic             vblnk_i,
  input  ship_pkg::rgb_t   rgb_i,

  // enemy missile positions
  input  ship_pkg::coord_t en_x_missile_i [ship_pkg::ENEMY_MISSILES],
  input  ship_pkg::coord_t en_y_missile_i [ship_pkg::ENEMY_MISSILES],

  output ship_pkg::coord_t hcount_o,
  output logic             hsync_o,
  output logic             hblnk_o,
  output ship_pkg::coord_t vcount_o,
  output logic             vsync_o,
  output logic             vblnk_o,
  output ship_pkg::rgb_t   rgb_o,

  output ship_pkg::coord_t xpos_missile_o,
  output ship_pkg::coord_t ypos_missile_o,
  output logic             on_missile_o,
  output logic             ship_dead_o
);
  import ship_pkg::*;

  coord_t ship_x;
  logic   ship_dead;
  coord_t missile_x;
  coord_t missile_y;
  logic   missile_on;

  // input bundle, sprite stage output, missile stage output
  vga_if v_in ();
  vga_if v_mid ();
  vga_if v_out ();

  assign v_in.hcount = hcount_i;
  assign v_in.hsync  = hsync_i;
  assign v_in.hblnk  = hblnk_i;
  assign v_in.vcount = vcount_i;
  assign v_in.vsync  = vsync_i;
  assign v_in.vblnk  = vblnk_i;
  assign v_in.rgb    = rgb_i;

  ship_position_ctl my_ship_position_ctl (
    .pclk     (pclk),
    .rst_n_i  (rst_n_i),
    .left_i   (left_i),
    .right_i  (right_i),
    .vsync_i  (vsync_i),
    .ship_x_o (ship_x)
  );

  collision_detect my_collision_detect (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .ship_x_i    (ship_x),
    .en_x_i      (en_x_missile_i),
    .en_y_i      (en_y_missile_i),
    .ship_dead_o (ship_dead)
  );

  // two cycles
  ship_sprite_draw my_ship_sprite_draw (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .ship_x_i    (ship_x),
    .ship_dead_i (ship_dead),
    .vin         (v_in.snk),
    .vout        (v_mid.src)
  );

  missile_ctl my_missile_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .fire_i       (missile_button_i),
    .ship_x_i     (ship_x),
    .ship_dead_i  (ship_dead),
    .vsync_i      (vsync_i),
    .missile_x_o  (missile_x),
    .missile_y_o  (missile_y),
    .missile_on_o (missile_on)
  );

  // one cycle
  missile_draw my_missile_draw (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .missile_x_i  (missile_x),
    .missile_y_i  (missile_y),
    .missile_on_i (missile_on),
    .vin          (v_mid.snk),
    .vout         (v_out.src)
  );

  assign hcount_o = v_out.hcount;
  assign hsync_o  = v_out.hsync;
  assign hblnk_o  = v_out.hblnk;
  assign vcount_o = v_out.vcount;
  assign vsync_o  = v_out.vsync;
  assign vblnk_o  = v_out.vblnk;
  assign rgb_o    = v_out.rgb;

  assign xpos_missile_o = missile_x;
  assign ypos_missile_o = missile_y;
  assign on_missile_o   = missile_on;
  assign ship_dead_o    = ship_dead;

endmodule

/* rtl/missile_draw.sv */
`timescale 1ns/10ps

module missile_draw (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  ship_pkg::coord_t missile_x_i,
  input  ship_pkg::coord_t missile_y_i,
  input  logic             missile_on_i,
  vga_if.snk               vin,
  vga_if.src               vout
);
  import ship_pkg::*;

  logic in_rect;
  logic draw;

  assign in_rect = (vin.hcount >= missile_x_i) &&
                   (int'(vin.hcount) < int'(missile_x_i) + MISSILE_W) &&
                   (vin.vcount >= missile_y_i) &&
                   (int'(vin.vcount) < int'(missile_y_i) + MISSILE_H);

  // never paint into blanking
  assign draw = missile_on_i && in_rect && !vin.hblnk && !vin.vblnk;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vout.vcount <= '0;
      vout.vsync  <= 1'b0;
      vout.vblnk  <= 1'b0;
      vout.hcount <= '0;
      vout.hsync  <= 1'b0;
      vout.hblnk  <= 1'b0;
      vout.rgb    <= '0;
    end else begin
      vout.vcount <= vin.vcount;
      vout.vsync  <= vin.vsync;
      vout.vblnk  <= vin.vblnk;
      vout.hcount <= vin.hcount;
      vout.hsync  <= vin.hsync;
      vout.hblnk  <= vin.hblnk;
      vout.rgb    <= draw ? MISSILE_COLOR : vin.rgb;
    end
  end

endmodule

/* rtl/missile_ctl.sv */
`timescale 1ns/10ps

module missile_ctl (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  logic             fire_i,
  input  ship_pkg::coord_t ship_x_i,
  input  logic             ship_dead_i,
  input  logic             vsync_i,
  output ship_pkg::coord_t missile_x_o,
  output ship_pkg::coord_t missile_y_o,
  output logic             missile_on_o
);
  import ship_pkg::*;

  logic vsync_d;
  logic frame_tick;
  logic launch;

  assign frame_tick = vsync_i & ~vsync_d;

  // dead ship cannot fire, a missile in flight still finishes
  assign launch = fire_i && !missile_on_o && !ship_dead_i;

  // missile_on_o is the state, idle when low and flying when high
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vsync_d      <= 1'b0;
      missile_on_o <= 1'b0;
      missile_x_o  <= '0;
      missile_y_o  <= '0;
    end else begin
      vsync_d <= vsync_i;
      if (launch) begin
        // start just above the ship, centred on it
        missile_on_o <= 1'b1;
        missile_x_o  <= ship_x_i + coord_t'(MISSILE_X_OFS);
        missile_y_o  <= coord_t'(SHIP_Y - MISSILE_H);
      end else if (frame_tick && missile_on_o) begin
        if (int'(missile_y_o) < MISSILE_STEP) begin
          // reached the top of the screen
          missile_on_o <= 1'b0;
        end else begin
          missile_y_o <= missile_y_o - coord_t'(MISSILE_STEP);
        end
      end
    end
  end

endmodule

/* rtl/ship_sprite_draw.sv */
`timescale 1ns/10ps

module ship_sprite_draw (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  ship_pkg::coord_t ship_x_i,
  input  logic             ship_dead_i,
  vga_if.snk               vin,
  vga_if.src               vout
);
  import ship_pkg::*;

  logic                     in_box;
  logic                     in_box_d;
  logic                     draw;
  coord_t                   row;
  coord_t                   col;
  logic [SPRITE_ADDR_W-1:0] rom_addr;
  rgb_t                     rom_rgb;

  // stage 1 copy of the bundle
  coord_t vcount_d;
  logic   vsync_d;
  logic   vblnk_d;
  coord_t hcount_d;
  logic   hsync_d;
  logic   hblnk_d;
  rgb_t   rgb_d;

  assign in_box = (vin.hcount >= ship_x_i) &&
                  (int'(vin.hcount) < int'(ship_x_i) + SHIP_W) &&
                  (int'(vin.vcount) >= SHIP_Y) &&
                  (int'(vin.vcount) < SHIP_Y + SHIP_H);

  assign col = vin.hcount - ship_x_i;
  assign row = vin.vcount - coord_t'(SHIP_Y);

  // pixels outside the box read address zero
  assign rom_addr = in_box ? SPRITE_ADDR_W'(int'(row) * SHIP_W + int'(col)) : '0;

  ship_sprite_rom my_ship_sprite_rom (
    .pclk   (pclk),
    .addr_i (rom_addr),
    .rgb_o  (rom_rgb)
  );

  // stage 1, rom lookup runs alongside
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vcount_d <= '0;
      vsync_d  <= 1'b0;
      vblnk_d  <= 1'b0;
      hcount_d <= '0;
      hsync_d  <= 1'b0;
      hblnk_d  <= 1'b0;
      rgb_d    <= '0;
      in_box_d <= 1'b0;
    end else begin
      vcount_d <= vin.vcount;
      vsync_d  <= vin.vsync;
      vblnk_d  <= vin.vblnk;
      hcount_d <= vin.hcount;
      hsync_d  <= vin.hsync;
      hblnk_d  <= vin.hblnk;
      rgb_d    <= vin.rgb;
      in_box_d <= in_box;
    end
  end

  // key colour lets the background through
  assign draw = in_box_d && !ship_dead_i && !hblnk_d && !vblnk_d &&
                (rom_rgb != TRANSPARENT);

  // stage 2, overlay
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vout.vcount <= '0;
      vout.vsync  <= 1'b0;
      vout.vblnk  <= 1'b0;
      vout.hcount <= '0;
      vout.hsync  <= 1'b0;
      vout.hblnk  <= 1'b0;
      vout.rgb    <= '0;
    end else begin
      vout.vcount <= vcount_d;
      vout.vsync  <= vsync_d;
      vout.vblnk  <= vblnk_d;
      vout.hcount <= hcount_d;
      vout.hsync  <= hsync_d;
      vout.hblnk  <= hblnk_d;
      vout.rgb    <= draw ? rom_rgb : rgb_d;
    end
  end

endmodule

/* rtl/ship_sprite_rom.sv */
`timescale 1ns/10ps

module ship_sprite_rom (
  input  logic                               pclk,
  input  logic [ship_pkg::SPRITE_ADDR_W-1:0] addr_i,
  output ship_pkg::rgb_t                     rgb_o
);
  import ship_pkg::*;

  rgb_t mem [SPRITE_DEPTH];

  // contents come from the shared colour rule
  initial begin
    for (int r = 0; r < SHIP_H; r++) begin
      for (int c = 0; c < SHIP_W; c++) begin
        mem[r * SHIP_W + c] = sprite_color(r, c);
      end
    end
  end

  // registered read, one cycle
  always_ff @(posedge pclk) begin
    rgb_o <= mem[addr_i];
  end

endmodule

/* rtl/collision_detect.sv */
`timescale 1ns/10ps

module collision_detect (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  ship_pkg::coord_t ship_x_i,
  input  ship_pkg::coord_t en_x_i [ship_pkg::ENEMY_MISSILES],
  input  ship_pkg::coord_t en_y_i [ship_pkg::ENEMY_MISSILES],
  output logic             ship_dead_o
);
  import ship_pkg::*;

  logic [ENEMY_MISSILES-1:0] hit;
  logic                      in_x;
  logic                      in_y;

  // all enemy missiles tested in parallel against the ship box
  always_comb begin
    hit  = '0;
    in_x = 1'b0;
    in_y = 1'b0;
    for (int i = 0; i < ENEMY_MISSILES; i++) begin
      in_x = (en_x_i[i] >= ship_x_i) &&
             (int'(en_x_i[i]) < int'(ship_x_i) + SHIP_W);
      in_y = (int'(en_y_i[i]) >= SHIP_Y) &&
             (int'(en_y_i[i]) < SHIP_Y + SHIP_H);
      hit[i] = in_x && in_y;
    end
  end

  // sticky, only reset brings the ship back
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ship_dead_o <= 1'b0;
    end else if (|hit) begin
      ship_dead_o <= 1'b1;
    end
  end

endmodule

/* rtl/ship_position_ctl.sv */
`timescale 1ns/10ps

module ship_position_ctl (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  logic             left_i,
  input  logic             right_i,
  input  logic             vsync_i,
  output ship_pkg::coord_t ship_x_o
);
  import ship_pkg::*;

  logic   vsync_d;
  logic   frame_tick;
  coord_t ship_x_nxt;

  // rising edge of vsync starts a new frame
  assign frame_tick = vsync_i & ~vsync_d;

  always_comb begin
    ship_x_nxt = ship_x_o;
    if (left_i && !right_i) begin
      if (int'(ship_x_o) < SHIP_STEP) begin
        ship_x_nxt = '0;
      end else begin
        ship_x_nxt = ship_x_o - coord_t'(SHIP_STEP);
      end
    end else if (right_i && !left_i) begin
      // stop with the right edge of the sprite on the last column
      if (int'(ship_x_o) > SHIP_X_MAX - SHIP_STEP) begin
        ship_x_nxt = coord_t'(SHIP_X_MAX);
      end else begin
        ship_x_nxt = ship_x_o + coord_t'(SHIP_STEP);
      end
    end
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vsync_d  <= 1'b0;
      ship_x_o <= coord_t'(SHIP_X_INIT);
    end else begin
      vsync_d <= vsync_i;
      if (frame_tick) begin
        ship_x_o <= ship_x_nxt;
      end
    end
  end

endmodule

/* rtl/vga_if.sv */
`timescale 1ns/10ps

interface vga_if;
  import ship_pkg::*;

  coord_t vcount;
  logic   vsync;
  logic   vblnk;
  coord_t hcount;
  logic   hsync;
  logic   hblnk;
  rgb_t   rgb;

  // driving draw stage
  modport src (output vcount, vsync, vblnk, hcount, hsync, hblnk, rgb);

  // receiving draw stage
  modport snk (input vcount, vsync, vblnk, hcount, hsync, hblnk, rgb);

endinterface

/* rtl/ship_pkg.sv */
package ship_pkg;

  // screen coordinate and 4:4:4 pixel colour
  typedef logic [10:0] coord_t;
  typedef logic [11:0] rgb_t;

  localparam int SCREEN_W = 1024;

  // player ship sprite
  localparam int SHIP_W      = 64;
  localparam int SHIP_H      = 48;
  localparam int SHIP_Y      = 680;
  localparam int SHIP_X_INIT = 480;
  localparam int SHIP_STEP   = 4;
  localparam int SHIP_X_MAX  = SCREEN_W - SHIP_W;

  // row * SHIP_W + column
  localparam int   SPRITE_ADDR_W = 12;
  localparam int   SPRITE_DEPTH  = SHIP_W * SHIP_H;
  localparam rgb_t TRANSPARENT   = 12'h000;

  // player missile
  localparam int   MISSILE_W     = 4;
  localparam int   MISSILE_H     = 12;
  localparam int   MISSILE_STEP  = 8;
  localparam int   MISSILE_X_OFS = (SHIP_W - MISSILE_W) / 2;
  localparam rgb_t MISSILE_COLOR = 12'hff0;

  localparam int ENEMY_MISSILES = 3;

  // trapezoid hull, narrowing towards the bottom rows
  function automatic rgb_t sprite_color(input int row, input int col);
    int half;
    half = row / 2;
    if ((col < half) || (col >= SHIP_W - half)) begin
      return TRANSPARENT;
    end
    // red follows the row, green the column
    return {4'(row), 4'(col), 4'hf};
  endfunction

endpackage
